/* alu_core.f */
verilog/cla_pkg.sv
verilog/alu_isa_pkg.sv
verilog/cla4.sv
verilog/cla16.sv
verilog/cla32.sv
verilog/alu_decode.sv
verilog/alu_execute.sv
verilog/alu_result.sv
verilog/alu_core.sv
test/alu_core_props.sv
test/alu_core_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module alu_core_tb -f alu_core.f -o alu_core_sim \
    && ./obj_dir/alu_core_sim \
    || { echo "Simulation did not complete successfully"; exit 1; }

/* test/alu_core_props.sv */
`timescale 1ns/1ps

module alu_core_props (
    input logic                clk,
    input logic                rst_n,
    input logic                in_valid,
    input alu_isa_pkg::instr_u instr,
    input logic                result_valid,
    input logic                flags_valid,
    input cla_pkg::flags_t     flags
);
    import alu_isa_pkg::*;

    // Fixed three-cycle latency from strobe to flags pulse
    latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        flags_valid == $past(in_valid, 3))
        else $error("flags_valid does not follow in_valid by three cycles");

    // A compare never produces a result pulse
    no_cmp_result_a: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> ($past(in_valid, 3) && ($past(instr.r.opcode, 3) != op_cmp)))
        else $error("result_valid without a writing operation three cycles earlier");

    // Outputs stay quiet while in reset
    reset_quiet_a: assert property (@(posedge clk)
        !rst_n |-> (!flags_valid && !result_valid))
        else $error("Output pulse while rst_n is low");

    // Flag register leaves reset cleared
    reset_flags_a: assert property (@(posedge clk)
        $rose(rst_n) |-> (flags == '0))
        else $error("Flag register not cleared by reset");

endmodule

bind alu_core alu_core_props u_props (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .instr(instr),
    .result_valid(result_valid), .flags_valid(flags_valid), .flags(flags)
);

/* test/alu_core_tb.sv */
`timescale 1ns/1ps

module alu_core_tb;
    import alu_isa_pkg::*;
    import cla_pkg::*;

    localparam int num_directed = 29;
    localparam int num_random   = 200;
    localparam int clk_period   = 20;

    // Expected response of one operation
    typedef struct packed {
        logic                  write_result;
        logic [data_width-1:0] result;
        flags_t                flags;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    instr_u                instr;
    logic [data_width-1:0] opnd_a;
    logic [data_width-1:0] opnd_b;
    logic                  result_valid;
    logic [data_width-1:0] result;
    logic                  flags_valid;
    flags_t                flags;

    expect_t exp_q[$];
    string   name_q[$];
    logic    model_carry;
    integer  seed;

    alu_core UUT (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .instr(instr),
        .opnd_a(opnd_a), .opnd_b(opnd_b), .result_valid(result_valid),
        .result(result), .flags_valid(flags_valid), .flags(flags)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic expect_t model_op(input alu_op_e op, input logic [data_width-1:0] a,
                                         input logic [data_width-1:0] b, input logic cy);
        expect_t             e;
        logic [data_width:0] wide;
        logic [data_width:0] cin_w;
        logic                extra;
        e              = '0;
        e.write_result = (op != op_cmp);
        e.flags.carry  = cy;
        // Carry in for adc, borrow in for sbb
        extra = (op == op_adc) ? cy : ((op == op_sbb) ? ~cy : 1'b0);
        cin_w = {{data_width{1'b0}}, extra};
        case (op)
            op_and: e.result = a & b;
            op_or:  e.result = a | b;
            op_xor: e.result = a ^ b;
            op_add, op_adc: begin
                wide             = {1'b0, a} + {1'b0, b} + cin_w;
                e.result         = wide[sign_bit:0];
                e.flags.carry    = wide[data_width];
                e.flags.overflow = (a[sign_bit] == b[sign_bit])
                                 && (e.result[sign_bit] != a[sign_bit]);
            end
            default: begin
                // Carry set means no borrow
                wide             = {1'b0, a} - {1'b0, b} - cin_w;
                e.result         = wide[sign_bit:0];
                e.flags.carry    = ~wide[data_width];
                e.flags.overflow = (a[sign_bit] != b[sign_bit])
                                 && (e.result[sign_bit] != a[sign_bit]);
            end
        endcase
        e.flags.zero     = (e.result == '0);
        e.flags.negative = e.result[sign_bit];
        return e;
    endfunction

    task automatic issue(input string name, input alu_op_e op, input logic fmt,
                         input logic [imm_width-1:0] imm, input logic [data_width-1:0] a,
                         input logic [data_width-1:0] b);
        logic [data_width-1:0] b_eff;
        expect_t               e;
        @(negedge clk);
        b_eff = fmt ? {{(data_width - imm_width){imm[imm_width-1]}}, imm} : b;
        if (fmt) begin
            instr.i = '{opcode: op, fmt: 1'b1, imm: imm};
        end else begin
            instr.r = '{opcode: op, fmt: 1'b0, rsvd: imm};
        end
        in_valid = 1'b1;
        opnd_a   = a;
        opnd_b   = b;
        e = model_op(op, a, b_eff, model_carry);
        model_carry = e.flags.carry;
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    // Pulls rst_n low while two operations are still in the pipeline
    task automatic reset_in_flight();
        @(negedge clk);
        in_valid = 1'b0;
        repeat (4) @(negedge clk);
        issue("lost_in_execute", op_add, 1'b0, 11'h000, 32'hffffffff, 32'h00000002);
        issue("lost_in_decode",  op_sub, 1'b0, 11'h000, 32'h00000001, 32'h00000002);
        @(negedge clk);
        in_valid = 1'b0;
        rst_n    = 1'b0;
        // Operations in flight are dropped by the reset
        exp_q.delete();
        name_q.delete();
        model_carry = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [data_width-1:0] exp_val,
                                   input logic [data_width-1:0] act_val);
        $display("CHECK FAILED test=%s %s expected=%h actual=%h", name, what, exp_val, act_val);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // Compare each flags pulse against the oldest expected entry
    always @(negedge clk) begin
        expect_t e;
        string   name;
        if (rst_n && flags_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("Flags pulse arrived with no operation in flight");
                $display("=== FAIL ===");
                $fatal(1);
            end
            e    = exp_q.pop_front();
            name = name_q.pop_front();
            assert (result_valid == e.write_result)
                else report_mismatch(name, "result_valid", data_width'(e.write_result),
                                     data_width'(result_valid));
            if (e.write_result) begin
                assert (result == e.result) else report_mismatch(name, "result", e.result, result);
            end
            assert (flags == e.flags)
                else report_mismatch(name, "flags", data_width'(e.flags), data_width'(flags));
        end
    end

    initial begin
        #((num_directed + num_random + 100) * clk_period);
        $display("Watchdog expired before all operations completed");
        $display("=== FAIL ===");
        $fatal(1);
    end

    initial begin
        logic [data_width-1:0] r_bits;
        logic [data_width-1:0] r_a;
        logic [data_width-1:0] r_b;
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        instr       = '0;
        opnd_a      = '0;
        opnd_b      = '0;
        model_carry = 1'b0;
        seed        = 28;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Carry flag must start cleared
        issue("adc_after_reset", op_adc, 1'b0, 11'h000, 32'h00000000, 32'h00000000);
        issue("add_all_ones",  op_add, 1'b0, 11'h000, 32'hffffffff, 32'h00000001);
        issue("add_nibble",    op_add, 1'b0, 11'h000, 32'h0000000f, 32'h00000001);
        issue("add_group16",   op_add, 1'b0, 11'h000, 32'h0000ffff, 32'h00000001);
        issue("add_ovf_pos",   op_add, 1'b0, 11'h000, 32'h7fffffff, 32'h00000001);
        issue("add_ovf_neg",   op_add, 1'b0, 11'h000, 32'h80000000, 32'h80000000);
        issue("sub_simple",    op_sub, 1'b0, 11'h000, 32'h00000005, 32'h00000003);
        issue("sub_borrow",    op_sub, 1'b0, 11'h000, 32'h00000003, 32'h00000005);
        issue("sub_ovf",       op_sub, 1'b0, 11'h000, 32'h80000000, 32'h00000001);
        issue("cmp_equal",     op_cmp, 1'b0, 11'h000, 32'h00001234, 32'h00001234);
        issue("cmp_less",      op_cmp, 1'b0, 11'h000, 32'h00000001, 32'h00000002);
        // 64-bit sum and difference over two back-to-back operations
        issue("chain_add_lo",  op_add, 1'b0, 11'h000, 32'hffffffff, 32'h00000001);
        issue("chain_adc_hi",  op_adc, 1'b0, 11'h000, 32'h00000001, 32'h00000002);
        issue("chain_sub_lo",  op_sub, 1'b0, 11'h000, 32'h00000000, 32'h00000001);
        issue("chain_sbb_hi",  op_sbb, 1'b0, 11'h000, 32'h00000005, 32'h00000002);
        issue("imm_add_neg",   op_add, 1'b1, 11'h7ff, 32'h0000000a, 32'hdeadbeef);
        issue("imm_add_pos",   op_add, 1'b1, 11'h3ff, 32'h00000001, 32'hdeadbeef);
        issue("imm_sub_neg",   op_sub, 1'b1, 11'h7f0, 32'h00000005, 32'hdeadbeef);
        issue("imm_and_neg",   op_and, 1'b1, 11'h400, 32'hffff1234, 32'h00000000);
        issue("set_carry",     op_add, 1'b0, 11'h000, 32'hffffffff, 32'hffffffff);
        issue("and_zero",      op_and, 1'b0, 11'h000, 32'hf0f0f0f0, 32'h0f0f0f0f);
        issue("or_negative",   op_or,  1'b0, 11'h000, 32'h80000000, 32'h00000001);
        issue("xor_self",      op_xor, 1'b0, 11'h000, 32'h5a5a5a5a, 32'h5a5a5a5a);
        issue("clear_carry",   op_sub, 1'b0, 11'h000, 32'h00000001, 32'h00000002);
        issue("xor_keep_zero", op_xor, 1'b0, 11'h000, 32'h12345678, 32'h0f0f0f0f);

        // Leave carry and negative set, then reset with work in flight
        issue("flags_before_reset", op_add, 1'b0, 11'h000, 32'hffffffff, 32'hffffffff);
        reset_in_flight();
        issue("adc_after_mid_reset", op_adc, 1'b0, 11'h000, 32'h00000000, 32'h00000000);

        for (int n = 0; n < num_random; n++) begin
            r_bits = $random(seed);
            r_a    = $random(seed);
            r_b    = $random(seed);
            // Occasional equal operands to reach zero results
            if (r_bits[8:6] == 3'd0) begin
                r_b = r_a;
            end
            issue("random", alu_op_e'({1'b0, r_bits[2:0]}), r_bits[3], r_bits[31:21], r_a, r_b);
        end

        @(negedge clk);
        in_valid = 1'b0;
        repeat (5) @(negedge clk);
        if (exp_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Operations still pending after the pipeline drained");
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

endmodule

/* verilog/alu_core.sv */
`timescale 1ns/1ps

module alu_core (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  alu_isa_pkg::instr_u            instr,
    input  logic [cla_pkg::data_width-1:0] opnd_a,
    input  logic [cla_pkg::data_width-1:0] opnd_b,
    output logic                           result_valid,
    output logic [cla_pkg::data_width-1:0] result,
    output logic                           flags_valid,
    output cla_pkg::flags_t                flags
);
    import alu_isa_pkg::*;
    import cla_pkg::*;

    // Decode to execute
    logic                  dec_valid;
    uop_t                  dec_uop;
    logic [data_width-1:0] dec_a;
    logic [data_width-1:0] dec_b;

    // Execute to result
    logic                  ex_valid;
    uop_t                  ex_uop;
    logic [data_width-1:0] ex_value;
    flags_t                ex_flags;

    alu_decode u_decode (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .instr(instr),
        .opnd_a(opnd_a), .opnd_b(opnd_b), .dec_valid(dec_valid),
        .dec_uop(dec_uop), .dec_a(dec_a), .dec_b(dec_b)
    );

    alu_execute u_execute (
        .clk(clk), .rst_n(rst_n), .dec_valid(dec_valid), .dec_uop(dec_uop),
        .dec_a(dec_a), .dec_b(dec_b), .ex_valid(ex_valid), .ex_uop(ex_uop),
        .ex_value(ex_value), .ex_flags(ex_flags)
    );

    alu_result u_result (
        .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_uop(ex_uop),
        .ex_value(ex_value), .ex_flags(ex_flags), .result_valid(result_valid),
        .result(result), .flags_valid(flags_valid), .flags(flags)
    );

endmodule

/* verilog/alu_decode.sv */
`timescale 1ns/1ps

module alu_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  alu_isa_pkg::instr_u            instr,
    input  logic [cla_pkg::data_width-1:0] opnd_a,
    input  logic [cla_pkg::data_width-1:0] opnd_b,
    output logic                           dec_valid,
    output alu_isa_pkg::uop_t              dec_uop,
    output logic [cla_pkg::data_width-1:0] dec_a,
    output logic [cla_pkg::data_width-1:0] dec_b
);
    import alu_isa_pkg::*;
    import cla_pkg::*;

    uop_t                  uop;
    logic [data_width-1:0] imm_ext;
    logic [data_width-1:0] b_sel;

    // Control bits from the opcode
    always_comb begin
        uop = '{op: op_add, is_sub: 1'b0, use_carry: 1'b0, logic_sel: logic_and,
                is_logic: 1'b0, write_result: 1'b1};
        case (instr.r.opcode)
            op_adc: begin
                uop.op        = op_adc;
                uop.use_carry = 1'b1;
            end
            op_sub: begin
                uop.op     = op_sub;
                uop.is_sub = 1'b1;
            end
            op_sbb: begin
                uop.op        = op_sbb;
                uop.is_sub    = 1'b1;
                uop.use_carry = 1'b1;
            end
            op_cmp: begin
                uop.op           = op_cmp;
                uop.is_sub       = 1'b1;
                uop.write_result = 1'b0;
            end
            op_and: begin
                uop.op       = op_and;
                uop.is_logic = 1'b1;
            end
            op_or: begin
                uop.op        = op_or;
                uop.is_logic  = 1'b1;
                uop.logic_sel = logic_or;
            end
            op_xor: begin
                uop.op        = op_xor;
                uop.is_logic  = 1'b1;
                uop.logic_sel = logic_xor;
            end
            // op_add and every undefined opcode keep the add defaults
            default: ;
        endcase
    end

    // Immediate form reads the same word through the other view
    assign imm_ext = {{(data_width - imm_width){instr.i.imm[imm_width-1]}}, instr.i.imm};
    assign b_sel   = instr.r.fmt ? imm_ext : opnd_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_uop <= uop;
            dec_a   <= opnd_a;
            dec_b   <= b_sel;
        end
    end

endmodule

/* verilog/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           dec_valid,
    input  alu_isa_pkg::uop_t              dec_uop,
    input  logic [cla_pkg::data_width-1:0] dec_a,
    input  logic [cla_pkg::data_width-1:0] dec_b,
    output logic                           ex_valid,
    output alu_isa_pkg::uop_t              ex_uop,
    output logic [cla_pkg::data_width-1:0] ex_value,
    output cla_pkg::flags_t                ex_flags
);
    import alu_isa_pkg::*;
    import cla_pkg::*;

    logic                  carry_q;
    logic [data_width-1:0] add_b;
    logic                  add_cin;
    logic [data_width-1:0] sum;
    logic                  sum_cout;
    logic                  sum_ovf;
    logic [data_width-1:0] logic_val;
    logic [data_width-1:0] value;
    flags_t                flags_nxt;

    // Subtract is a + ~b + 1, borrow variants take the carry flag instead
    assign add_b   = dec_uop.is_sub ? ~dec_b : dec_b;
    assign add_cin = dec_uop.use_carry ? carry_q : dec_uop.is_sub;

    cla32 adder (
        .a        (dec_a),
        .b        (add_b),
        .cin      (add_cin),
        .s        (sum),
        .cout     (sum_cout),
        .overflow (sum_ovf)
    );

    always_comb begin
        case (dec_uop.logic_sel)
            logic_or:  logic_val = dec_a | dec_b;
            logic_xor: logic_val = dec_a ^ dec_b;
            default:   logic_val = dec_a & dec_b;
        endcase
    end

    assign value = dec_uop.is_logic ? logic_val : sum;

    // Zero and negative are filled in by the result stage
    always_comb begin
        flags_nxt          = '0;
        flags_nxt.carry    = dec_uop.is_logic ? carry_q : sum_cout;
        flags_nxt.overflow = dec_uop.is_logic ? 1'b0 : sum_ovf;
    end

    // Carry flag, written by every adder op including compare
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            carry_q  <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
            if (dec_valid) begin
                carry_q <= flags_nxt.carry;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_uop   <= dec_uop;
            ex_value <= value;
            ex_flags <= flags_nxt;
        end
    end

endmodule

/* verilog/alu_isa_pkg.sv */
package alu_isa_pkg;

    // Width of the immediate field in the immediate form
    localparam int imm_width = 11;

    // Logic unit selects
    localparam logic [1:0] logic_and = 2'd0;
    localparam logic [1:0] logic_or  = 2'd1;
    localparam logic [1:0] logic_xor = 2'd2;

    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_adc = 4'd1,
        op_sub = 4'd2,
        op_sbb = 4'd3,
        op_cmp = 4'd4,
        op_and = 4'd5,
        op_or  = 4'd6,
        op_xor = 4'd7
    } alu_op_e;

    // Register form, operand b from the port
    typedef struct packed {
        logic [3:0]           opcode;
        logic                 fmt;
        logic [imm_width-1:0] rsvd;
    } instr_r_t;

    // Immediate form, operand b from imm
    typedef struct packed {
        logic [3:0]           opcode;
        logic                 fmt;
        logic [imm_width-1:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        alu_op_e    op;
        logic       is_sub;
        logic       use_carry;
        logic [1:0] logic_sel;
        logic       is_logic;
        logic       write_result;
    } uop_t;

endpackage

/* verilog/alu_result.sv */
`timescale 1ns/1ps

module alu_result (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           ex_valid,
    input  alu_isa_pkg::uop_t              ex_uop,
    input  logic [cla_pkg::data_width-1:0] ex_value,
    input  cla_pkg::flags_t                ex_flags,
    output logic                           result_valid,
    output logic [cla_pkg::data_width-1:0] result,
    output logic                           flags_valid,
    output cla_pkg::flags_t                flags
);
    import alu_isa_pkg::*;
    import cla_pkg::*;

    flags_t flags_nxt;

    // Carry and overflow come from execute
    always_comb begin
        flags_nxt          = ex_flags;
        flags_nxt.zero     = (ex_value == '0);
        flags_nxt.negative = ex_value[sign_bit];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            flags_valid  <= 1'b0;
            flags        <= '0;
        end else begin
            flags_valid  <= ex_valid;
            result_valid <= ex_valid & ex_uop.write_result;
            if (ex_valid) begin
                flags <= flags_nxt;
            end
        end
    end

    // Compare leaves the last result in place
    always_ff @(posedge clk) begin
        if (ex_valid && ex_uop.write_result) begin
            result <= ex_value;
        end
    end

endmodule

/* verilog/cla16.sv */
`timescale 1ns/1ps

module cla16 (
    input  logic [15:0] a,
    input  logic [15:0] b,
    input  logic        cin,
    output logic [15:0] s,
    output logic        cout,
    output logic        gg,
    output logic        pg
);

    logic [3:0] bg;
    logic [3:0] bp;
    logic       c4;
    logic       c8;
    logic       c12;

    // Block carry-outs stay open, the second level drives the carries
    cla4 blk0 (.a(a[3:0]),   .b(b[3:0]),   .cin(cin), .s(s[3:0]),
               .cout(), .gg(bg[0]), .pg(bp[0]));
    cla4 blk1 (.a(a[7:4]),   .b(b[7:4]),   .cin(c4),  .s(s[7:4]),
               .cout(), .gg(bg[1]), .pg(bp[1]));
    cla4 blk2 (.a(a[11:8]),  .b(b[11:8]),  .cin(c8),  .s(s[11:8]),
               .cout(), .gg(bg[2]), .pg(bp[2]));
    cla4 blk3 (.a(a[15:12]), .b(b[15:12]), .cin(c12), .s(s[15:12]),
               .cout(), .gg(bg[3]), .pg(bp[3]));

    // Carry into bit 4
    assign c4 = bg[0] | (bp[0] & cin);

    // Carry into bit 8
    assign c8 = bg[1] | (bp[1] & bg[0]) | (bp[1] & bp[0] & cin);

    // Carry into bit 12
    assign c12 = bg[2] | (bp[2] & bg[1]) | (bp[2] & bp[1] & bg[0])
               | (bp[2] & bp[1] & bp[0] & cin);

    // Group generate and propagate over all four blocks
    assign gg = bg[3] | (bp[3] & bg[2]) | (bp[3] & bp[2] & bg[1])
              | (bp[3] & bp[2] & bp[1] & bg[0]);
    assign pg = bp[3] & bp[2] & bp[1] & bp[0];

    assign cout = gg | (pg & cin);

endmodule

/* verilog/cla32.sv */
`timescale 1ns/1ps

module cla32 (
    input  logic [cla_pkg::data_width-1:0] a,
    input  logic [cla_pkg::data_width-1:0] b,
    input  logic                           cin,
    output logic [cla_pkg::data_width-1:0] s,
    output logic                           cout,
    output logic                           overflow
);
    import cla_pkg::*;

    logic g_lo;
    logic p_lo;
    logic g_hi;
    logic p_hi;
    logic c16;

    cla16 grp_lo (.a(a[half_width-1:0]), .b(b[half_width-1:0]), .cin(cin),
                  .s(s[half_width-1:0]), .cout(), .gg(g_lo), .pg(p_lo));

    cla16 grp_hi (.a(a[sign_bit:half_width]), .b(b[sign_bit:half_width]), .cin(c16),
                  .s(s[sign_bit:half_width]), .cout(), .gg(g_hi), .pg(p_hi));

    // Lookahead for the carry into the upper group
    assign c16 = g_lo | (p_lo & cin);

    // Final carry
    assign cout = g_hi | (p_hi & g_lo) | (p_hi & p_lo & cin);

    // Inputs agree in sign but the sum does not
    assign overflow = (a[sign_bit] ~^ b[sign_bit]) & (s[sign_bit] ^ a[sign_bit]);

endmodule

/* verilog/cla4.sv */
`timescale 1ns/1ps

module cla4 (
    input  logic [3:0] a,
    input  logic [3:0] b,
    input  logic       cin,
    output logic [3:0] s,
    output logic       cout,
    output logic       gg,
    output logic       pg
);

    logic [3:0] g;
    logic [3:0] p;
    logic       c1;
    logic       c2;
    logic       c3;

    // Per-bit generate and propagate
    assign g = a & b;
    assign p = a ^ b;

    // Lookahead for c1
    assign c1 = g[0] | (p[0] & cin);

    // Lookahead for c2
    assign c2 = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);

    // Lookahead for c3
    assign c3 = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & cin);

    // Group terms for the next level up
    assign gg = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
              | (p[3] & p[2] & p[1] & g[0]);
    assign pg = p[3] & p[2] & p[1] & p[0];

    // Carry out of the block
    assign cout = gg | (pg & cin);

    assign s = p ^ {c3, c2, c1, cin};

endmodule

/* verilog/cla_pkg.sv */
package cla_pkg;

    // Operand and result width
    localparam int data_width = 32;

    // Position of the sign bit
    localparam int sign_bit = data_width - 1;

    // Half width, the split point between the two 16-bit groups
    localparam int half_width = data_width / 2;

    // Status flags as kept by the ALU
    typedef struct packed {
        logic carry;
        logic overflow;
        logic zero;
        logic negative;
    } flags_t;

endpackage
